// File: design/dram_macros.svh
`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

// channel count and word geometry
`define DRAM_NUM_CH 2
`define DRAM_ADDR_W 12
`define DRAM_DATA_W 32
`define DRAM_MASK_W 4

// address fields from the msb down
`define DRAM_ROW_W 4
`define DRAM_BANK_W 2
`define DRAM_COL_W 4
`define DRAM_OFF_W 2

// per-channel queue depth and initial credit count
`define DRAM_QUEUE_DEPTH 4

// access latencies in cycles
`define DRAM_LAT_HIT 4
`define DRAM_LAT_EMPTY 7
`define DRAM_LAT_MISS 10

`endif

// File: design/dram_pkg.sv
`include "dram_macros.svh"

package dram_pkg;

  // field view of one channel address
  typedef struct packed {
    logic [`DRAM_ROW_W-1:0]  row;
    logic [`DRAM_BANK_W-1:0] bank;
    logic [`DRAM_COL_W-1:0]  col;
    logic [`DRAM_OFF_W-1:0]  off;
  } dram_addr_fields_t;

  // flat word or decoded fields
  typedef union packed {
    logic [`DRAM_ADDR_W-1:0] raw;
    dram_addr_fields_t       f;
  } dram_addr_u;

  // one queued request
  typedef struct packed {
    logic                    write_not_read;
    dram_addr_u              addr;
    logic [`DRAM_DATA_W-1:0] data;
    logic [`DRAM_MASK_W-1:0] mask;
  } dram_req_t;

  typedef enum logic {
    BANK_CLOSED = 1'b0,
    BANK_OPEN   = 1'b1
  } dram_bank_state_t;

endpackage

// File: design/dram_req_if.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

// request path from channel wrapper into its queue
// no ready since the sender spends a credit on every valid cycle
interface dram_req_if;

  logic                    v;
  logic                    write_not_read;
  logic [`DRAM_ADDR_W-1:0] addr;
  logic [`DRAM_DATA_W-1:0] data;
  logic [`DRAM_MASK_W-1:0] mask;

  modport sender (
    output v,
    output write_not_read,
    output addr,
    output data,
    output mask
  );

  modport receiver (
    input v,
    input write_not_read,
    input addr,
    input data,
    input mask
  );

endinterface

// File: design/dram_req_queue.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_req_queue import dram_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  dram_req_if.receiver        req_if,
  output logic                head_v_o,
  output dram_req_t           head_o,
  input  logic                pop_i,
  output logic                credit_o
);

  localparam int PTR_W = $clog2(`DRAM_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`DRAM_QUEUE_DEPTH + 1);

  dram_req_t        entries [`DRAM_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  dram_req_t        push_entry;

  assign push = req_if.v;

  always_comb begin
    push_entry.write_not_read = req_if.write_not_read;
    push_entry.addr.raw       = req_if.addr;
    push_entry.data           = req_if.data;
    push_entry.mask           = req_if.mask;
  end

  // pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(`DRAM_QUEUE_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop_i) begin
        if (rd_ptr == PTR_W'(`DRAM_QUEUE_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      if (push && !pop_i) begin
        count <= count + 1'b1;
      end else if (!push && pop_i) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      entries[wr_ptr] <= push_entry;
    end
  end

  assign head_v_o = (count != '0);
  assign head_o   = entries[rd_ptr];

  // each completed request frees one slot
  assign credit_o = pop_i;

endmodule

// File: design/dram_bank_timer.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_bank_timer import dram_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      head_v_i,
  input  dram_req_t head_i,
  output logic      pop_o
);

  localparam int NUM_BANKS = 1 << `DRAM_BANK_W;
  localparam int CNT_W     = $clog2(`DRAM_LAT_MISS);

  dram_bank_state_t        bank_state [NUM_BANKS];
  logic [`DRAM_ROW_W-1:0]  open_row   [NUM_BANKS];

  logic                    busy;
  logic [CNT_W-1:0]        cnt;
  logic                    start;
  logic [CNT_W-1:0]        lat;
  logic [`DRAM_BANK_W-1:0] head_bank;
  logic [`DRAM_ROW_W-1:0]  head_row;

  assign head_bank = head_i.addr.f.bank;
  assign head_row  = head_i.addr.f.row;

  assign start = head_v_i && !busy;

  // classify against the open row of the target bank
  always_comb begin
    if (bank_state[head_bank] == BANK_CLOSED) begin
      lat = CNT_W'(`DRAM_LAT_EMPTY);
    end else if (open_row[head_bank] == head_row) begin
      lat = CNT_W'(`DRAM_LAT_HIT);
    end else begin
      lat = CNT_W'(`DRAM_LAT_MISS);
    end
  end

  // pop lands exactly lat cycles after the start cycle
  assign pop_o = busy && (cnt == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy <= 1'b0;
      cnt  <= '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_state[b] <= BANK_CLOSED;
      end
    end else begin
      if (start) begin
        busy <= 1'b1;
        cnt  <= lat - 1'b1;
      end else if (busy) begin
        if (cnt == '0) begin
          busy                  <= 1'b0;
          bank_state[head_bank] <= BANK_OPEN;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  // head stays put until pop, so its row is still valid here
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      open_row[head_bank] <= head_row;
    end
  end

endmodule

// File: design/dram_channel_store.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_channel_store (
  input  logic                                              clk_i,
  input  logic                                              we_i,
  input  logic                                              re_i,
  input  logic [`DRAM_ROW_W+`DRAM_BANK_W+`DRAM_COL_W-1:0]   word_i,
  input  logic [`DRAM_DATA_W-1:0]                           data_i,
  input  logic [`DRAM_MASK_W-1:0]                           mask_i,
  output logic [`DRAM_DATA_W-1:0]                           data_o
);

  localparam int WORD_W = `DRAM_ROW_W + `DRAM_BANK_W + `DRAM_COL_W;
  localparam int DEPTH  = 1 << WORD_W;

  logic [`DRAM_DATA_W-1:0] mem [DEPTH];

  // model memory reads zero until written
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < `DRAM_MASK_W; b++) begin
        if (mask_i[b]) begin
          mem[word_i][b*8 +: 8] <= data_i[b*8 +: 8];
        end
      end
    end
  end

  // one cycle read
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      data_o <= mem[word_i];
    end
  end

endmodule

// File: design/dram_channel.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_channel import dram_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_v_i,
  input  logic                    req_write_not_read_i,
  input  logic [`DRAM_ADDR_W-1:0] req_addr_i,
  input  logic [`DRAM_DATA_W-1:0] req_data_i,
  input  logic [`DRAM_MASK_W-1:0] req_mask_i,
  output logic                    credit_o,
  output logic                    rd_v_o,
  output logic [`DRAM_DATA_W-1:0] rd_data_o,
  output logic [`DRAM_ADDR_W-1:0] rd_addr_o,
  output logic                    write_done_o,
  output logic [`DRAM_ADDR_W-1:0] write_done_addr_o
);

  dram_req_if req_if ();

  logic      head_v;
  dram_req_t head;
  logic      pop;
  logic      store_we;
  logic      store_re;

  assign req_if.v              = req_v_i;
  assign req_if.write_not_read = req_write_not_read_i;
  assign req_if.addr           = req_addr_i;
  assign req_if.data           = req_data_i;
  assign req_if.mask           = req_mask_i;

  dram_req_queue req_queue_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_if   (req_if.receiver),
    .head_v_o (head_v),
    .head_o   (head),
    .pop_i    (pop),
    .credit_o (credit_o)
  );

  dram_bank_timer bank_timer_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .head_v_i (head_v),
    .head_i   (head),
    .pop_o    (pop)
  );

  assign store_we = pop && head.write_not_read;
  assign store_re = pop && !head.write_not_read;

  dram_channel_store store_i (
    .clk_i  (clk_i),
    .we_i   (store_we),
    .re_i   (store_re),
    .word_i ({head.addr.f.row, head.addr.f.bank, head.addr.f.col}),
    .data_i (head.data),
    .mask_i (head.mask),
    .data_o (rd_data_o)
  );

  // writes complete in the pop cycle
  assign write_done_o      = store_we;
  assign write_done_addr_o = head.addr.raw;

  // line valid and address up with the store output
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_o <= 1'b0;
    end else begin
      rd_v_o <= store_re;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_re) begin
      rd_addr_o <= head.addr.raw;
    end
  end

endmodule

// File: design/dram_top.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_top (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [`DRAM_NUM_CH-1:0]                   req_v_i,
  input  logic [`DRAM_NUM_CH-1:0]                   req_write_not_read_i,
  input  logic [`DRAM_NUM_CH-1:0][`DRAM_ADDR_W-1:0] req_addr_i,
  input  logic [`DRAM_NUM_CH-1:0][`DRAM_DATA_W-1:0] req_data_i,
  input  logic [`DRAM_NUM_CH-1:0][`DRAM_MASK_W-1:0] req_mask_i,
  output logic [`DRAM_NUM_CH-1:0]                   credit_o,
  output logic [`DRAM_NUM_CH-1:0]                   rd_v_o,
  output logic [`DRAM_NUM_CH-1:0][`DRAM_DATA_W-1:0] rd_data_o,
  output logic [`DRAM_NUM_CH-1:0][`DRAM_ADDR_W-1:0] rd_addr_o,
  output logic [`DRAM_NUM_CH-1:0]                   write_done_o,
  output logic [`DRAM_NUM_CH-1:0][`DRAM_ADDR_W-1:0] write_done_addr_o
);

  // channels share only clock and reset
  for (genvar c = 0; c < `DRAM_NUM_CH; c++) begin : g_ch
    dram_channel channel_i (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .req_v_i              (req_v_i[c]),
      .req_write_not_read_i (req_write_not_read_i[c]),
      .req_addr_i           (req_addr_i[c]),
      .req_data_i           (req_data_i[c]),
      .req_mask_i           (req_mask_i[c]),
      .credit_o             (credit_o[c]),
      .rd_v_o               (rd_v_o[c]),
      .rd_data_o            (rd_data_o[c]),
      .rd_addr_o            (rd_addr_o[c]),
      .write_done_o         (write_done_o[c]),
      .write_done_addr_o    (write_done_addr_o[c])
    );
  end

endmodule

// File: testbench/dram_assert.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_req_queue_assert (
  input logic                                     clk_i,
  input logic                                     reset_i,
  input logic                                     push_i,
  input logic [$clog2(`DRAM_QUEUE_DEPTH + 1)-1:0] count_i,
  input logic                                     pop_i,
  input logic                                     credit_i
);

  // a sender with a credit never finds the queue full
  push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (32'(count_i) < `DRAM_QUEUE_DEPTH))
    else $error("request pushed into a full queue");

  // a credit only comes back from an entry that leaves
  credit_from_entry: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_i |-> (count_i != '0))
    else $error("credit returned while the queue was empty");

  credit_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !credit_i)
    else $error("credit pulse while reset is held");

endmodule

bind dram_req_queue dram_req_queue_assert req_queue_assert_i (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .push_i   (push),
  .count_i  (count),
  .pop_i    (pop_i),
  .credit_i (credit_o)
);

// File: testbench/tb_dram_top.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module tb_dram_top;

  localparam int NCH   = `DRAM_NUM_CH;
  localparam int WORDS = 1 << (`DRAM_ROW_W + `DRAM_BANK_W + `DRAM_COL_W);
  localparam int EXPQ  = 16;
  localparam int ENT_W = 1 + `DRAM_ADDR_W + `DRAM_DATA_W;
  // twice the time of 53 requests that all miss with slack
  localparam int WDOG_CYC = 2 * 53 * (`DRAM_LAT_MISS + 2) + 100;

  logic                             clk;
  logic                             reset;
  logic [NCH-1:0]                   req_v;
  logic [NCH-1:0]                   req_wnr;
  logic [NCH-1:0][`DRAM_ADDR_W-1:0] req_addr;
  logic [NCH-1:0][`DRAM_DATA_W-1:0] req_data;
  logic [NCH-1:0][`DRAM_MASK_W-1:0] req_mask;
  logic [NCH-1:0]                   credit;
  logic [NCH-1:0]                   rd_v;
  logic [NCH-1:0][`DRAM_DATA_W-1:0] rd_data;
  logic [NCH-1:0][`DRAM_ADDR_W-1:0] rd_addr;
  logic [NCH-1:0]                   wr_done;
  logic [NCH-1:0][`DRAM_ADDR_W-1:0] wr_done_addr;

  // reference model and expected completions as {write, addr, read data}
  logic [`DRAM_DATA_W-1:0] ref_mem   [NCH][WORDS];
  logic                    bank_open [NCH][4];
  logic [`DRAM_ROW_W-1:0]  bank_row  [NCH][4];
  logic [ENT_W-1:0]        exp_q     [NCH][EXPQ];
  int                      exp_head  [NCH];
  int                      exp_tail  [NCH];
  logic [`DRAM_DATA_W-1:0] last_rd   [NCH];
  int                      credits   [NCH];
  logic [NCH-1:0]          credit_pend;
  int                      done_cnt  [NCH];
  int                      done_cyc  [NCH];
  int                      cyc;
  int                      issue_cyc;
  int                      last_lat;
  int                      test_err;
  int                      total_err;
  int                      tests_run;
  string                   cur_test;

  dram_top dram_top_i (
    .clk_i                (clk),
    .reset_i              (reset),
    .req_v_i              (req_v),
    .req_write_not_read_i (req_wnr),
    .req_addr_i           (req_addr),
    .req_data_i           (req_data),
    .req_mask_i           (req_mask),
    .credit_o             (credit),
    .rd_v_o               (rd_v),
    .rd_data_o            (rd_data),
    .rd_addr_o            (rd_addr),
    .write_done_o         (wr_done),
    .write_done_addr_o    (wr_done_addr)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic log_error(input string line);
    $display("%s", line);
    test_err++;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_err += test_err;
    $display("test %s finished with %0d errors", cur_test, test_err);
  endtask

  task automatic retire(input int c, input logic is_wr, input logic [`DRAM_ADDR_W-1:0] addr,
                        input logic [`DRAM_DATA_W-1:0] data);
    logic [ENT_W-1:0] e;
    done_cnt[c]++;
    done_cyc[c] = cyc;
    assert (exp_head[c] != exp_tail[c])
      else log_error($sformatf("channel %0d completed a request it never received", c));
    e = exp_q[c][exp_head[c]];
    exp_head[c] = (exp_head[c] + 1) % EXPQ;
    assert (e[ENT_W-1] == is_wr)
      else log_error($sformatf("mismatch %s: write flag expected %0d actual %0d",
                               cur_test, e[ENT_W-1], is_wr));
    assert (e[`DRAM_DATA_W +: `DRAM_ADDR_W] == addr)
      else log_error($sformatf("mismatch %s: address expected %h actual %h",
                               cur_test, e[`DRAM_DATA_W +: `DRAM_ADDR_W], addr));
    if (!is_wr) begin
      last_rd[c] = data;
      assert (e[`DRAM_DATA_W-1:0] == data)
        else log_error($sformatf("mismatch %s: read data expected %h actual %h",
                                 cur_test, e[`DRAM_DATA_W-1:0], data));
    end
  endtask

  // outputs are stable at the falling edge and inputs change there
  task automatic tick();
    @(negedge clk);
    cyc++;
    req_v = '0;
    for (int c = 0; c < NCH; c++) begin
      // a returned credit is spent no earlier than the next cycle
      if (credit_pend[c]) begin
        credits[c]++;
      end
      credit_pend[c] = credit[c];
      if (rd_v[c]) begin
        retire(c, 1'b0, rd_addr[c], rd_data[c]);
      end
      if (wr_done[c]) begin
        retire(c, 1'b1, wr_done_addr[c], '0);
      end
    end
  endtask

  task automatic issue(input int c, input logic wnr, input logic [`DRAM_ADDR_W-1:0] addr,
                       input logic [`DRAM_DATA_W-1:0] data,
                       input logic [`DRAM_MASK_W-1:0] mask);
    int w;
    int b;
    w = int'(addr[11:2]);
    b = int'(addr[7:6]);
    while (credits[c] == 0) begin
      tick();
    end
    if (!bank_open[c][b]) begin
      last_lat = `DRAM_LAT_EMPTY;
    end else if (bank_row[c][b] == addr[11:8]) begin
      last_lat = `DRAM_LAT_HIT;
    end else begin
      last_lat = `DRAM_LAT_MISS;
    end
    bank_open[c][b] = 1'b1;
    bank_row[c][b]  = addr[11:8];
    // a read sees every earlier write on its in-order channel
    exp_q[c][exp_tail[c]] = {wnr, addr, ref_mem[c][w]};
    exp_tail[c] = (exp_tail[c] + 1) % EXPQ;
    for (int k = 0; k < `DRAM_MASK_W; k++) begin
      if (wnr && mask[k]) begin
        ref_mem[c][w][k*8 +: 8] = data[k*8 +: 8];
      end
    end
    credits[c]--;
    req_v[c]    = 1'b1;
    req_wnr[c]  = wnr;
    req_addr[c] = addr;
    req_data[c] = data;
    req_mask[c] = mask;
    issue_cyc   = cyc;
    tick();
  endtask

  task automatic drain();
    for (int c = 0; c < NCH; c++) begin
      while (exp_head[c] != exp_tail[c]) begin
        tick();
      end
    end
    repeat (2) tick();
  endtask

  task automatic write_then_read();
    begin_test("write_read");
    issue(0, 1'b1, 12'h124, 32'hdeadbeef, 4'hf);
    issue(0, 1'b0, 12'h124, '0, 4'hf);
    drain();
    assert (last_rd[0] == 32'hdeadbeef)
      else log_error($sformatf("mismatch %s: data expected deadbeef actual %h",
                               cur_test, last_rd[0]));
    end_test();
  endtask

  task automatic partial_mask_write();
    begin_test("partial_mask");
    issue(0, 1'b1, 12'h124, 32'h11223344, 4'b0101);
    issue(0, 1'b0, 12'h124, '0, 4'hf);
    drain();
    assert (last_rd[0] == 32'hde22be44)
      else log_error($sformatf("mismatch %s: data expected de22be44 actual %h",
                               cur_test, last_rd[0]));
    issue(0, 1'b0, 12'h8f0, '0, 4'hf);
    drain();
    assert (last_rd[0] == '0)
      else log_error($sformatf("mismatch %s: data expected 0 actual %h", cur_test, last_rd[0]));
    end_test();
  endtask

  // bank 2 of channel 1 is still closed here
  task automatic latency_classes();
    int lat [3];
    int base;
    int prev;
    begin_test("latency");
    base = done_cnt[1];
    issue(1, 1'b1, 12'h180, 32'h1, 4'hf);
    lat[0] = last_lat;
    prev = issue_cyc;
    issue(1, 1'b1, 12'h18c, 32'h2, 4'hf);
    lat[1] = last_lat;
    issue(1, 1'b1, 12'h580, 32'h3, 4'hf);
    lat[2] = last_lat;
    assert (lat[0] == `DRAM_LAT_EMPTY && lat[1] == `DRAM_LAT_HIT && lat[2] == `DRAM_LAT_MISS)
      else log_error("bank model did not see the sequence as empty, hit, miss");
    for (int k = 0; k < 3; k++) begin
      while (done_cnt[1] < base + k + 1) begin
        tick();
      end
      assert (done_cyc[1] - prev - 1 == lat[k])
        else log_error($sformatf("mismatch %s: gap %0d expected %0d actual %0d",
                                 cur_test, k, lat[k], done_cyc[1] - prev - 1));
      prev = done_cyc[1];
    end
    drain();
    end_test();
  endtask

  task automatic credit_stall();
    int base;
    int stall_from;
    begin_test("credits");
    base = done_cnt[0];
    issue(0, 1'b1, 12'h210, 32'h0a0a0a0a, 4'hf);
    issue(0, 1'b1, 12'h220, 32'h0b0b0b0b, 4'hf);
    issue(0, 1'b0, 12'h210, '0, 4'hf);
    issue(0, 1'b0, 12'h220, '0, 4'hf);
    assert (credits[0] == 0)
      else log_error($sformatf("mismatch %s: credits expected 0 actual %0d", cur_test, credits[0]));
    stall_from = cyc;
    issue(0, 1'b0, 12'h8f0, '0, 4'hf);
    assert (issue_cyc > stall_from && done_cnt[0] > base)
      else log_error("requester did not wait for a returned credit");
    drain();
    assert (credits[0] == `DRAM_QUEUE_DEPTH)
      else log_error($sformatf("mismatch %s: credits expected %0d actual %0d",
                               cur_test, `DRAM_QUEUE_DEPTH, credits[0]));
    end_test();
  endtask

  // small address range so reads often find written words
  task automatic random_traffic();
    logic [`DRAM_ADDR_W-1:0] addr;
    begin_test("random");
    for (int i = 0; i < 20; i++) begin
      for (int c = 0; c < NCH; c++) begin
        addr = 12'($urandom) & 12'h1cc;
        issue(c, 1'($urandom), addr, $urandom, 4'($urandom));
      end
    end
    drain();
    end_test();
  endtask

  initial begin
    void'($urandom(63382));
    reset = 1'b1;
    req_v = '0;
    req_wnr = '0;
    req_addr = '0;
    req_data = '0;
    req_mask = '0;
    credit_pend = '0;
    cyc = 0;
    total_err = 0;
    tests_run = 0;
    cur_test = "reset";
    for (int c = 0; c < NCH; c++) begin
      credits[c] = `DRAM_QUEUE_DEPTH;
      exp_head[c] = 0;
      exp_tail[c] = 0;
      done_cnt[c] = 0;
      for (int b = 0; b < 4; b++) begin
        bank_open[c][b] = 1'b0;
      end
      for (int w = 0; w < WORDS; w++) begin
        ref_mem[c][w] = '0;
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    write_then_read();
    partial_mask_write();
    latency_classes();
    credit_stall();
    random_traffic();
    $display("%0d tests run, %0d checks failed", tests_run, total_err);
    if (total_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles in test %s", WDOG_CYC, cur_test);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: build.f
+incdir+design
design/dram_pkg.sv
design/dram_req_if.sv
design/dram_req_queue.sv
design/dram_bank_timer.sv
design/dram_channel_store.sv
design/dram_channel.sv
design/dram_top.sv
testbench/dram_assert.sv
testbench/tb_dram_top.sv

// File: run.sh
#!/bin/sh
# build the DRAM model testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dram_top -f build.f \
  && ./obj_dir/Vtb_dram_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
